/* design/bus_map_pkg.sv */
`default_nettype none

package bus_map_pkg;

  // write-only serial data register
  localparam logic [31:0] UART_ADDR = 32'h0f00_0000;

  // mtime is read as two word-aligned halves
  localparam logic [31:0] MTIME_LO_ADDR = 32'h0200_bff8;
  localparam logic [31:0] MTIME_HI_ADDR = 32'h0200_bffc;

  // half-word view of the timer
  typedef struct packed {
    logic [31:0] hi;
    logic [31:0] lo;
  } mtime_half_t;

  // counted as one 64-bit word, read back one half at a time
  typedef union packed {
    logic [63:0] full;
    mtime_half_t half;
  } mtime_u;

endpackage

`default_nettype wire

/* design/axi_pkg.sv */
`default_nettype none

package axi_pkg;

  // response field width on r and b channels
  localparam int RESP_W = 2;

  // byte strobes for a 32-bit data path
  localparam int STRB_W = 4;

  typedef enum logic [RESP_W-1:0] {
    OKAY   = 2'b00,
    EXOKAY = 2'b01,
    SLVERR = 2'b10,
    DECERR = 2'b11
  } axi_resp_e;

endpackage

`default_nettype wire

/* design/dev_if.sv */
`timescale 1ns/1ps
`default_nettype none

interface dev_if #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) ();

  // request side, held steady until done
  logic [ADDR_W-1:0]   addr;
  logic [DATA_W-1:0]   wdata;
  logic [DATA_W/8-1:0] wstrb;
  logic                rd;
  logic                wr;

  // response side, done and err are single-cycle pulses
  logic [DATA_W-1:0]   rdata;
  logic                done;
  logic                err;

  modport host (
    output addr, wdata, wstrb, rd, wr,
    input  rdata, done, err
  );

  modport dev (
    input  addr, wdata, wstrb, rd, wr,
    output rdata, done, err
  );

endinterface

`default_nettype wire

/* design/clint_timer.sv */
`timescale 1ns/1ps
`default_nettype none

module clint_timer #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic clk,
  input  logic rst,
  dev_if.dev   bus
);
  import bus_map_pkg::*;

  mtime_u            mtime;
  logic              done_q;
  logic [DATA_W-1:0] rdata_q;
  logic              rd_start;
  logic              sel_hi;

  // rd is still high in the done cycle, so don't start again then
  assign rd_start = bus.rd && !done_q;
  assign sel_hi   = (bus.addr == ADDR_W'(MTIME_HI_ADDR));

  // free-running, zero in the first cycle out of reset
  always_ff @(posedge clk)
  begin
    if (rst)
      mtime.full <= '0;
    else
      mtime.full <= mtime.full + 64'd1;
  end

  always_ff @(posedge clk)
  begin
    if (rst)
      done_q <= 1'b0;
    else
      done_q <= rd_start;
  end

  // value seen at the edge that accepts the read
  always_ff @(posedge clk)
  begin
    if (rd_start)
    begin
      if (sel_hi)
        rdata_q <= DATA_W'(mtime.half.hi);
      else
        rdata_q <= DATA_W'(mtime.half.lo);
    end
  end

  assign bus.rdata = rdata_q;
  assign bus.done  = done_q;
  assign bus.err   = 1'b0;

endmodule

`default_nettype wire

/* design/uart_sink.sv */
`timescale 1ns/1ps
`default_nettype none

module uart_sink (
  input  logic       clk,
  input  logic       rst,
  dev_if.dev         bus,
  output logic [7:0] uart_data_o,
  output logic       uart_valid_o
);

  logic done_q;
  logic wr_start;

  // wr stays high through the done cycle
  assign wr_start = bus.wr && !done_q;

  always_ff @(posedge clk)
  begin
    if (rst)
      done_q <= 1'b0;
    else
      done_q <= wr_start;
  end

  // keeps the last byte until the next write
  always_ff @(posedge clk)
  begin
    if (wr_start)
      uart_data_o <= bus.wdata[7:0];
  end

  assign uart_valid_o = done_q;

  // write-only port, nothing to read back
  assign bus.done  = done_q;
  assign bus.rdata = '0;
  assign bus.err   = 1'b0;

endmodule

`default_nettype wire

/* design/axi_master_bridge.sv */
`timescale 1ns/1ps
`default_nettype none

module axi_master_bridge #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                       clk,
  input  logic                       rst,
  dev_if.dev                         bus,
  output logic [ADDR_W-1:0]          ext_araddr_o,
  output logic                       ext_arvalid_o,
  input  logic                       ext_arready_i,
  input  logic [DATA_W-1:0]          ext_rdata_i,
  input  axi_pkg::axi_resp_e         ext_rresp_i,
  input  logic                       ext_rvalid_i,
  output logic [ADDR_W-1:0]          ext_awaddr_o,
  output logic                       ext_awvalid_o,
  input  logic                       ext_awready_i,
  output logic [DATA_W-1:0]          ext_wdata_o,
  output logic [axi_pkg::STRB_W-1:0] ext_wstrb_o,
  output logic                       ext_wvalid_o,
  input  logic                       ext_wready_i,
  input  axi_pkg::axi_resp_e         ext_bresp_i,
  input  logic                       ext_bvalid_i
);
  import axi_pkg::*;

  localparam logic [2:0] ST_IDLE  = 3'd0;
  localparam logic [2:0] ST_RADDR = 3'd1;
  localparam logic [2:0] ST_RDATA = 3'd2;
  localparam logic [2:0] ST_WRITE = 3'd3;
  localparam logic [2:0] ST_WRESP = 3'd4;

  logic [2:0]        state;
  logic              arvalid_q;
  logic              awvalid_q;
  logic              wvalid_q;
  logic              done_q;
  logic              err_q;
  logic [DATA_W-1:0] rdata_q;
  logic              aw_ok;
  logic              w_ok;

  function automatic logic is_err(input axi_resp_e resp);
    return (resp == SLVERR) || (resp == DECERR);
  endfunction

  // aw and w accepted independently, either may land first
  assign aw_ok = !awvalid_q || ext_awready_i;
  assign w_ok  = !wvalid_q || ext_wready_i;

  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      state     <= ST_IDLE;
      arvalid_q <= 1'b0;
      awvalid_q <= 1'b0;
      wvalid_q  <= 1'b0;
      done_q    <= 1'b0;
      err_q     <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      err_q  <= 1'b0;
      case (state)
        ST_IDLE:
        begin
          // done_q blocks a restart while the host still holds rd or wr
          if (bus.rd && !done_q)
          begin
            state     <= ST_RADDR;
            arvalid_q <= 1'b1;
          end
          else if (bus.wr && !done_q)
          begin
            state     <= ST_WRITE;
            awvalid_q <= 1'b1;
            wvalid_q  <= 1'b1;
          end
        end
        ST_RADDR:
        begin
          if (ext_arready_i)
          begin
            arvalid_q <= 1'b0;
            state     <= ST_RDATA;
          end
        end
        ST_RDATA:
        begin
          if (ext_rvalid_i)
          begin
            done_q <= 1'b1;
            err_q  <= is_err(ext_rresp_i);
            state  <= ST_IDLE;
          end
        end
        ST_WRITE:
        begin
          if (ext_awready_i)
            awvalid_q <= 1'b0;
          if (ext_wready_i)
            wvalid_q <= 1'b0;
          if (aw_ok && w_ok)
            state <= ST_WRESP;
        end
        ST_WRESP:
        begin
          if (ext_bvalid_i)
          begin
            done_q <= 1'b1;
            err_q  <= is_err(ext_bresp_i);
            state  <= ST_IDLE;
          end
        end
        default: state <= ST_IDLE;
      endcase
    end
  end

  always_ff @(posedge clk)
  begin
    if ((state == ST_RDATA) && ext_rvalid_i)
      rdata_q <= ext_rdata_i;
  end

  // host keeps addr and data steady for the whole transfer
  assign ext_araddr_o  = bus.addr;
  assign ext_arvalid_o = arvalid_q;
  assign ext_awaddr_o  = bus.addr;
  assign ext_awvalid_o = awvalid_q;
  assign ext_wdata_o   = bus.wdata;
  assign ext_wstrb_o   = bus.wstrb;
  assign ext_wvalid_o  = wvalid_q;

  assign bus.rdata = rdata_q;
  assign bus.done  = done_q;
  assign bus.err   = err_q;

endmodule

`default_nettype wire

/* design/bus_arbiter.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_arbiter #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                      clk,
  input  logic                      rst,
  input  logic [ADDR_W-1:0]         ifu_araddr_i,
  input  logic                      ifu_arvalid_i,
  output logic [DATA_W-1:0]         ifu_rdata_o,
  output logic                      ifu_rvalid_o,
  output logic                      ifu_err_o,
  input  logic [ADDR_W-1:0]         lsu_araddr_i,
  input  logic                      lsu_arvalid_i,
  output logic [DATA_W-1:0]         lsu_rdata_o,
  output logic                      lsu_rvalid_o,
  input  logic [ADDR_W-1:0]         lsu_awaddr_i,
  input  logic [DATA_W-1:0]         lsu_wdata_i,
  input  logic [axi_pkg::STRB_W-1:0] lsu_wstrb_i,
  input  logic                      lsu_wvalid_i,
  output logic                      lsu_wready_o,
  output logic                      lsu_err_o,
  output logic [7:0]                uart_data_o,
  output logic                      uart_valid_o,
  dev_if.host                       mem
);
  import bus_map_pkg::*;

  localparam logic [1:0] OWN_IDLE  = 2'd0;
  localparam logic [1:0] OWN_FETCH = 2'd1;
  localparam logic [1:0] OWN_LOAD  = 2'd2;
  localparam logic [1:0] OWN_STORE = 2'd3;

  localparam logic [1:0] TGT_MEM   = 2'd0;
  localparam logic [1:0] TGT_TIMER = 2'd1;
  localparam logic [1:0] TGT_UART  = 2'd2;

  logic [1:0]        owner;
  logic [1:0]        tgt;
  logic              timer_hit;
  logic              uart_hit;
  logic [ADDR_W-1:0] req_addr;
  logic              req_rd;
  logic              req_wr;
  logic              sel_done;
  logic              sel_err;
  logic [DATA_W-1:0] sel_rdata;

  dev_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) timer_bus ();
  dev_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) uart_bus ();

  // only loads see the timer, only stores see the serial port
  assign timer_hit = (lsu_araddr_i == ADDR_W'(MTIME_LO_ADDR)) ||
                     (lsu_araddr_i == ADDR_W'(MTIME_HI_ADDR));
  assign uart_hit  = (lsu_awaddr_i == ADDR_W'(UART_ADDR));

  // one owner at a time, lsu ahead of fetch
  always_ff @(posedge clk)
  begin
    if (rst)
    begin
      owner <= OWN_IDLE;
      tgt   <= TGT_MEM;
    end
    else if (owner == OWN_IDLE)
    begin
      if (lsu_arvalid_i)
      begin
        owner <= OWN_LOAD;
        tgt   <= timer_hit ? TGT_TIMER : TGT_MEM;
      end
      else if (lsu_wvalid_i)
      begin
        owner <= OWN_STORE;
        tgt   <= uart_hit ? TGT_UART : TGT_MEM;
      end
      else if (ifu_arvalid_i)
      begin
        owner <= OWN_FETCH;
        tgt   <= TGT_MEM;
      end
    end
    else if (sel_done)
      owner <= OWN_IDLE;
  end

  always_comb
  begin
    case (owner)
      OWN_FETCH: req_addr = ifu_araddr_i;
      OWN_STORE: req_addr = lsu_awaddr_i;
      default:   req_addr = lsu_araddr_i;
    endcase
  end

  assign req_rd = (owner == OWN_FETCH) || (owner == OWN_LOAD);
  assign req_wr = (owner == OWN_STORE);

  assign mem.addr  = req_addr;
  assign mem.wdata = lsu_wdata_i;
  assign mem.wstrb = lsu_wstrb_i;
  assign mem.rd    = req_rd && (tgt == TGT_MEM);
  assign mem.wr    = req_wr && (tgt == TGT_MEM);

  assign timer_bus.addr  = req_addr;
  assign timer_bus.wdata = lsu_wdata_i;
  assign timer_bus.wstrb = lsu_wstrb_i;
  assign timer_bus.rd    = req_rd && (tgt == TGT_TIMER);
  assign timer_bus.wr    = req_wr && (tgt == TGT_TIMER);

  assign uart_bus.addr  = req_addr;
  assign uart_bus.wdata = lsu_wdata_i;
  assign uart_bus.wstrb = lsu_wstrb_i;
  assign uart_bus.rd    = req_rd && (tgt == TGT_UART);
  assign uart_bus.wr    = req_wr && (tgt == TGT_UART);

  // response from whichever target holds the request
  always_comb
  begin
    case (tgt)
      TGT_TIMER:
      begin
        sel_done  = timer_bus.done;
        sel_err   = timer_bus.err;
        sel_rdata = timer_bus.rdata;
      end
      TGT_UART:
      begin
        sel_done  = uart_bus.done;
        sel_err   = uart_bus.err;
        sel_rdata = uart_bus.rdata;
      end
      default:
      begin
        sel_done  = mem.done;
        sel_err   = mem.err;
        sel_rdata = mem.rdata;
      end
    endcase
  end

  // steer completion to the owning port only
  assign ifu_rdata_o  = sel_rdata;
  assign ifu_rvalid_o = (owner == OWN_FETCH) && sel_done;
  assign ifu_err_o    = (owner == OWN_FETCH) && sel_err;
  assign lsu_rdata_o  = sel_rdata;
  assign lsu_rvalid_o = (owner == OWN_LOAD) && sel_done;
  assign lsu_wready_o = (owner == OWN_STORE) && sel_done;
  assign lsu_err_o    = ((owner == OWN_LOAD) || (owner == OWN_STORE)) && sel_err;

  clint_timer #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_clint_timer (
    .clk (clk),
    .rst (rst),
    .bus (timer_bus)
  );

  uart_sink u_uart_sink (
    .clk          (clk),
    .rst          (rst),
    .bus          (uart_bus),
    .uart_data_o  (uart_data_o),
    .uart_valid_o (uart_valid_o)
  );

endmodule

`default_nettype wire

/* design/bus_top.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_top #(
  parameter int ADDR_W = 32,
  parameter int DATA_W = 32
) (
  input  logic                       clk,
  input  logic                       rst,
  input  logic [ADDR_W-1:0]          ifu_araddr_i,
  input  logic                       ifu_arvalid_i,
  output logic [DATA_W-1:0]          ifu_rdata_o,
  output logic                       ifu_rvalid_o,
  output logic                       ifu_err_o,
  input  logic [ADDR_W-1:0]          lsu_araddr_i,
  input  logic                       lsu_arvalid_i,
  output logic [DATA_W-1:0]          lsu_rdata_o,
  output logic                       lsu_rvalid_o,
  input  logic [ADDR_W-1:0]          lsu_awaddr_i,
  input  logic [DATA_W-1:0]          lsu_wdata_i,
  input  logic [axi_pkg::STRB_W-1:0] lsu_wstrb_i,
  input  logic                       lsu_wvalid_i,
  output logic                       lsu_wready_o,
  output logic                       lsu_err_o,
  output logic [7:0]                 uart_data_o,
  output logic                       uart_valid_o,
  output logic [ADDR_W-1:0]          ext_araddr_o,
  output logic                       ext_arvalid_o,
  input  logic                       ext_arready_i,
  input  logic [DATA_W-1:0]          ext_rdata_i,
  input  axi_pkg::axi_resp_e         ext_rresp_i,
  input  logic                       ext_rvalid_i,
  output logic [ADDR_W-1:0]          ext_awaddr_o,
  output logic                       ext_awvalid_o,
  input  logic                       ext_awready_i,
  output logic [DATA_W-1:0]          ext_wdata_o,
  output logic [axi_pkg::STRB_W-1:0] ext_wstrb_o,
  output logic                       ext_wvalid_o,
  input  logic                       ext_wready_i,
  input  axi_pkg::axi_resp_e         ext_bresp_i,
  input  logic                       ext_bvalid_i
);

  // arbiter to external memory bridge
  dev_if #(.ADDR_W(ADDR_W), .DATA_W(DATA_W)) mem_bus ();

  bus_arbiter #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_bus_arbiter (
    .clk           (clk),
    .rst           (rst),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_rdata_o   (ifu_rdata_o),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .ifu_err_o     (ifu_err_o),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .lsu_wvalid_i  (lsu_wvalid_i),
    .lsu_wready_o  (lsu_wready_o),
    .lsu_err_o     (lsu_err_o),
    .uart_data_o   (uart_data_o),
    .uart_valid_o  (uart_valid_o),
    .mem           (mem_bus)
  );

  axi_master_bridge #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) u_axi_master_bridge (
    .clk           (clk),
    .rst           (rst),
    .bus           (mem_bus),
    .ext_araddr_o  (ext_araddr_o),
    .ext_arvalid_o (ext_arvalid_o),
    .ext_arready_i (ext_arready_i),
    .ext_rdata_i   (ext_rdata_i),
    .ext_rresp_i   (ext_rresp_i),
    .ext_rvalid_i  (ext_rvalid_i),
    .ext_awaddr_o  (ext_awaddr_o),
    .ext_awvalid_o (ext_awvalid_o),
    .ext_awready_i (ext_awready_i),
    .ext_wdata_o   (ext_wdata_o),
    .ext_wstrb_o   (ext_wstrb_o),
    .ext_wvalid_o  (ext_wvalid_o),
    .ext_wready_i  (ext_wready_i),
    .ext_bresp_i   (ext_bresp_i),
    .ext_bvalid_i  (ext_bvalid_i)
  );

endmodule

`default_nettype wire

/* verif/bus_tb.sv */
`timescale 1ns/1ps
`default_nettype none

module bus_tb;
  import axi_pkg::*;
  import bus_map_pkg::*;

  localparam int ADDR_W     = 32;
  localparam int DATA_W     = 32;
  localparam int SEED       = 96430;
  // about 40 requests of at most 12 cycles each plus margin
  localparam int MAX_CYCLES = 2000;

  logic clk = 1'b0;
  logic rst;

  logic [ADDR_W-1:0] ifu_araddr_i;
  logic              ifu_arvalid_i;
  logic [DATA_W-1:0] ifu_rdata_o;
  logic              ifu_rvalid_o;
  logic              ifu_err_o;
  logic [ADDR_W-1:0] lsu_araddr_i;
  logic              lsu_arvalid_i;
  logic [DATA_W-1:0] lsu_rdata_o;
  logic              lsu_rvalid_o;
  logic [ADDR_W-1:0] lsu_awaddr_i;
  logic [DATA_W-1:0] lsu_wdata_i;
  logic [STRB_W-1:0] lsu_wstrb_i;
  logic              lsu_wvalid_i;
  logic              lsu_wready_o;
  logic              lsu_err_o;
  logic [7:0]        uart_data_o;
  logic              uart_valid_o;
  logic [ADDR_W-1:0] ext_araddr_o;
  logic              ext_arvalid_o;
  logic              ext_arready_i;
  logic [DATA_W-1:0] ext_rdata_i;
  axi_resp_e         ext_rresp_i;
  logic              ext_rvalid_i;
  logic [ADDR_W-1:0] ext_awaddr_o;
  logic              ext_awvalid_o;
  logic              ext_awready_i;
  logic [DATA_W-1:0] ext_wdata_o;
  logic [STRB_W-1:0] ext_wstrb_o;
  logic              ext_wvalid_o;
  logic              ext_wready_i;
  axi_resp_e         ext_bresp_i;
  logic              ext_bvalid_i;

  // memory model state
  logic [DATA_W-1:0] mem [0:255];
  logic [ADDR_W-1:0] rd_addr;
  logic [ADDR_W-1:0] wr_addr;
  logic [DATA_W-1:0] wr_data;
  logic [STRB_W-1:0] wr_strb;
  int                aw_lat;
  int                w_lat;
  int                k;

  logic [63:0] since_rst;
  int          cycle_cnt    = 0;
  int          mismatch_cnt = 0;
  int          fail_cnt     = 0;
  string       cur_test     = "reset";

  bus_top #(
    .ADDR_W(ADDR_W),
    .DATA_W(DATA_W)
  ) DUT (
    .clk           (clk),
    .rst           (rst),
    .ifu_araddr_i  (ifu_araddr_i),
    .ifu_arvalid_i (ifu_arvalid_i),
    .ifu_rdata_o   (ifu_rdata_o),
    .ifu_rvalid_o  (ifu_rvalid_o),
    .ifu_err_o     (ifu_err_o),
    .lsu_araddr_i  (lsu_araddr_i),
    .lsu_arvalid_i (lsu_arvalid_i),
    .lsu_rdata_o   (lsu_rdata_o),
    .lsu_rvalid_o  (lsu_rvalid_o),
    .lsu_awaddr_i  (lsu_awaddr_i),
    .lsu_wdata_i   (lsu_wdata_i),
    .lsu_wstrb_i   (lsu_wstrb_i),
    .lsu_wvalid_i  (lsu_wvalid_i),
    .lsu_wready_o  (lsu_wready_o),
    .lsu_err_o     (lsu_err_o),
    .uart_data_o   (uart_data_o),
    .uart_valid_o  (uart_valid_o),
    .ext_araddr_o  (ext_araddr_o),
    .ext_arvalid_o (ext_arvalid_o),
    .ext_arready_i (ext_arready_i),
    .ext_rdata_i   (ext_rdata_i),
    .ext_rresp_i   (ext_rresp_i),
    .ext_rvalid_i  (ext_rvalid_i),
    .ext_awaddr_o  (ext_awaddr_o),
    .ext_awvalid_o (ext_awvalid_o),
    .ext_awready_i (ext_awready_i),
    .ext_wdata_o   (ext_wdata_o),
    .ext_wstrb_o   (ext_wstrb_o),
    .ext_wvalid_o  (ext_wvalid_o),
    .ext_wready_i  (ext_wready_i),
    .ext_bresp_i   (ext_bresp_i),
    .ext_bvalid_i  (ext_bvalid_i)
  );

  always #50 clk = ~clk;

  // mtime is zero in the first cycle after reset
  always @(posedge clk)
  begin
    if (rst)
      since_rst <= '0;
    else
      since_rst <= since_rst + 64'd1;
  end

  always @(posedge clk)
  begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= MAX_CYCLES)
    begin
      $display("timeout after %0d cycles, no completion in test %s", cycle_cnt, cur_test);
      $display("sim failed");
      $finish;
    end
  end

  function automatic logic [DATA_W-1:0] fill_word(input int idx);
    logic [31:0] a;
    a = 32'(idx) << 2;
    return {~a[15:0], a[15:0]};
  endfunction

  function automatic axi_resp_e resp_for(input logic [ADDR_W-1:0] addr);
    return (addr >= 32'h8000_0000) ? DECERR : OKAY;
  endfunction

  function automatic logic [DATA_W-1:0] apply_strobes(input logic [DATA_W-1:0] old,
                                                      input logic [DATA_W-1:0] data,
                                                      input logic [STRB_W-1:0] strb);
    logic [DATA_W-1:0] res;
    res = old;
    for (int b = 0; b < STRB_W; b++)
      if (strb[b])
        res[8*b +: 8] = data[8*b +: 8];
    return res;
  endfunction

  // AXI-lite read slave with 0 to 3 cycles on ready and on data
  initial
  begin
    ext_arready_i = 1'b0;
    ext_rvalid_i  = 1'b0;
    ext_rdata_i   = '0;
    ext_rresp_i   = OKAY;
    forever
    begin
      @(negedge clk);
      if (ext_arvalid_o)
      begin
        repeat ($urandom % 4) @(negedge clk);
        ext_arready_i = 1'b1;
        rd_addr       = ext_araddr_o;
        @(negedge clk);
        ext_arready_i = 1'b0;
        repeat ($urandom % 4) @(negedge clk);
        ext_rdata_i  = mem[rd_addr[9:2]];
        ext_rresp_i  = resp_for(rd_addr);
        ext_rvalid_i = 1'b1;
        @(negedge clk);
        ext_rvalid_i = 1'b0;
      end
    end
  end

  // AXI-lite write slave accepting aw and w on their own cycles
  initial
  begin
    for (int i = 0; i < 256; i++)
      mem[i] = fill_word(i);
    ext_awready_i = 1'b0;
    ext_wready_i  = 1'b0;
    ext_bvalid_i  = 1'b0;
    ext_bresp_i   = OKAY;
    forever
    begin
      @(negedge clk);
      if (ext_awvalid_o)
      begin
        // aw and w rise together
        check_flag("write_model ext_wvalid_o rise", 1'b1, ext_wvalid_o);
        wr_addr = ext_awaddr_o;
        wr_data = ext_wdata_o;
        wr_strb = ext_wstrb_o;
        aw_lat  = $urandom % 4;
        w_lat   = $urandom % 4;
        for (k = 0; k <= ((aw_lat > w_lat) ? aw_lat : w_lat); k++)
        begin
          ext_awready_i = (k == aw_lat);
          ext_wready_i  = (k == w_lat);
          @(negedge clk);
        end
        // each valid gone after its own ready
        check_flag("write_model ext_awvalid_o drop", 1'b0, ext_awvalid_o);
        check_flag("write_model ext_wvalid_o drop", 1'b0, ext_wvalid_o);
        ext_awready_i = 1'b0;
        ext_wready_i  = 1'b0;
        if (resp_for(wr_addr) == OKAY)
          mem[wr_addr[9:2]] = apply_strobes(mem[wr_addr[9:2]], wr_data, wr_strb);
        repeat ($urandom % 4) @(negedge clk);
        ext_bresp_i  = resp_for(wr_addr);
        ext_bvalid_i = 1'b1;
        @(negedge clk);
        ext_bvalid_i = 1'b0;
      end
    end
  end

  task automatic check_data(input string name, input logic [DATA_W-1:0] exp,
                            input logic [DATA_W-1:0] act);
    if (act !== exp)
    begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_byte(input string name, input logic [7:0] exp, input logic [7:0] act);
    if (act !== exp)
    begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %h actual %h", name, exp, act);
    end
  endtask

  task automatic check_flag(input string name, input logic exp, input logic act);
    if (act !== exp)
    begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %b actual %b", name, exp, act);
    end
  endtask

  task automatic check_resp(input string name, input axi_resp_e exp, input logic act_err);
    logic exp_err;
    exp_err = (exp == SLVERR) || (exp == DECERR);
    if (act_err !== exp_err)
    begin
      mismatch_cnt++;
      $display("MISMATCH %s: expected %s (err %b) actual err %b", name, exp.name(), exp_err,
               act_err);
    end
  endtask

  task automatic check_idle_outputs(input string name);
    check_flag({name, " ifu_rvalid_o"}, 1'b0, ifu_rvalid_o);
    check_flag({name, " ifu_err_o"}, 1'b0, ifu_err_o);
    check_flag({name, " lsu_rvalid_o"}, 1'b0, lsu_rvalid_o);
    check_flag({name, " lsu_wready_o"}, 1'b0, lsu_wready_o);
    check_flag({name, " lsu_err_o"}, 1'b0, lsu_err_o);
    check_flag({name, " uart_valid_o"}, 1'b0, uart_valid_o);
    check_flag({name, " ext_arvalid_o"}, 1'b0, ext_arvalid_o);
    check_flag({name, " ext_awvalid_o"}, 1'b0, ext_awvalid_o);
    check_flag({name, " ext_wvalid_o"}, 1'b0, ext_wvalid_o);
  endtask

  // requester tasks start and end on a falling edge
  task automatic store_word(input logic [ADDR_W-1:0] addr, input logic [DATA_W-1:0] data,
                            input logic [STRB_W-1:0] strb, output logic err);
    lsu_awaddr_i = addr;
    lsu_wdata_i  = data;
    lsu_wstrb_i  = strb;
    lsu_wvalid_i = 1'b1;
    @(negedge clk);
    while (!lsu_wready_o)
      @(negedge clk);
    err          = lsu_err_o;
    lsu_wvalid_i = 1'b0;
  endtask

  task automatic load_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                           output logic err);
    lsu_araddr_i  = addr;
    lsu_arvalid_i = 1'b1;
    @(negedge clk);
    while (!lsu_rvalid_o)
      @(negedge clk);
    data          = lsu_rdata_o;
    err           = lsu_err_o;
    lsu_arvalid_i = 1'b0;
  endtask

  task automatic fetch_word(input logic [ADDR_W-1:0] addr, output logic [DATA_W-1:0] data,
                            output logic err);
    ifu_araddr_i  = addr;
    ifu_arvalid_i = 1'b1;
    @(negedge clk);
    while (!ifu_rvalid_o)
      @(negedge clk);
    data          = ifu_rdata_o;
    err           = ifu_err_o;
    ifu_arvalid_i = 1'b0;
  endtask

  task automatic reset_quiet();
    cur_test = "reset";
    repeat (10)
    begin
      @(negedge clk);
      check_idle_outputs("reset");
    end
    rst = 1'b0;
    repeat (3)
    begin
      @(negedge clk);
      check_idle_outputs("after_reset");
    end
  endtask

  task automatic fetch_after_store(input int count);
    logic [7:0]        idx;
    logic [ADDR_W-1:0] addr;
    logic [DATA_W-1:0] data;
    logic [STRB_W-1:0] strb;
    logic [DATA_W-1:0] exp;
    logic [DATA_W-1:0] got;
    logic              err;
    cur_test = "fetch_store";
    repeat (count)
    begin
      idx  = 8'($urandom);
      addr = 32'(idx) << 2;
      data = $urandom;
      strb = 4'($urandom);
      exp  = apply_strobes(mem[idx], data, strb);
      store_word(addr, data, strb, err);
      check_resp("fetch_store store", OKAY, err);
      check_data("fetch_store model", exp, mem[idx]);
      fetch_word(addr, got, err);
      check_resp("fetch_store fetch", OKAY, err);
      check_data("fetch_store fetch", exp, got);
    end
  endtask

  task automatic load_over_fetch();
    logic [7:0]        idx;
    logic [DATA_W-1:0] lsu_data;
    logic [DATA_W-1:0] ifu_data;
    int                n;
    int                lsu_at;
    int                ifu_at;
    cur_test = "load_priority";
    idx      = 8'($urandom % 128);
    n        = 0;
    lsu_at   = -1;
    ifu_at   = -1;
    // both raised on the same falling edge
    ifu_araddr_i  = 32'(idx) << 2;
    lsu_araddr_i  = 32'(idx + 8'd128) << 2;
    ifu_arvalid_i = 1'b1;
    lsu_arvalid_i = 1'b1;
    while ((lsu_at < 0) || (ifu_at < 0))
    begin
      @(negedge clk);
      n++;
      if (lsu_rvalid_o && (lsu_at < 0))
      begin
        lsu_at        = n;
        lsu_data      = lsu_rdata_o;
        lsu_arvalid_i = 1'b0;
      end
      if (ifu_rvalid_o && (ifu_at < 0))
      begin
        ifu_at        = n;
        ifu_data      = ifu_rdata_o;
        ifu_arvalid_i = 1'b0;
      end
    end
    if (lsu_at >= ifu_at)
    begin
      fail_cnt++;
      $display("load_priority: load finished at cycle %0d, not before fetch at cycle %0d",
               lsu_at, ifu_at);
    end
    check_data("load_priority load", mem[idx + 8'd128], lsu_data);
    check_data("load_priority fetch", mem[idx], ifu_data);
  endtask

  task automatic serial_store();
    logic [DATA_W-1:0] data;
    logic [7:0]        byte_seen;
    logic              uart_seen;
    logic              aw_seen;
    cur_test  = "serial_write";
    data      = $urandom;
    byte_seen = 8'h00;
    uart_seen = 1'b0;
    aw_seen   = 1'b0;
    lsu_awaddr_i = UART_ADDR;
    lsu_wdata_i  = data;
    lsu_wstrb_i  = 4'hf;
    lsu_wvalid_i = 1'b1;
    while (!lsu_wready_o)
    begin
      @(negedge clk);
      aw_seen = aw_seen | ext_awvalid_o;
      if (uart_valid_o)
      begin
        uart_seen = 1'b1;
        byte_seen = uart_data_o;
      end
    end
    check_resp("serial_write", OKAY, lsu_err_o);
    lsu_wvalid_i = 1'b0;
    check_flag("serial_write uart_valid_o", 1'b1, uart_seen);
    check_byte("serial_write uart_data_o", data[7:0], byte_seen);
    check_flag("serial_write ext_awvalid_o", 1'b0, aw_seen);
    // byte stays on the port after the pulse
    repeat (2) @(negedge clk);
    check_byte("serial_write held byte", data[7:0], uart_data_o);
  endtask

  task automatic timer_halves();
    logic [DATA_W-1:0] got;
    logic [63:0]       exp_t;
    logic              err;
    cur_test = "timer_read";
    load_word(MTIME_LO_ADDR, got, err);
    // sampled one edge before the done cycle
    exp_t = since_rst - 64'd1;
    check_resp("timer_read lo", OKAY, err);
    check_data("timer_read lo", exp_t[31:0], got);
    load_word(MTIME_HI_ADDR, got, err);
    exp_t = since_rst - 64'd1;
    check_resp("timer_read hi", OKAY, err);
    check_data("timer_read hi", exp_t[63:32], got);
  endtask

  task automatic error_load();
    logic [DATA_W-1:0] got;
    logic              err;
    cur_test = "error_response";
    load_word(32'h8000_0040, got, err);
    check_resp("error_response high load", DECERR, err);
    load_word(32'h0000_0040, got, err);
    check_resp("error_response normal load", OKAY, err);
    check_data("error_response normal load", mem[16], got);
  endtask

  initial
  begin
    void'($urandom(SEED));
    rst           = 1'b1;
    ifu_araddr_i  = '0;
    ifu_arvalid_i = 1'b0;
    lsu_araddr_i  = '0;
    lsu_arvalid_i = 1'b0;
    lsu_awaddr_i  = '0;
    lsu_wdata_i   = '0;
    lsu_wstrb_i   = '0;
    lsu_wvalid_i  = 1'b0;

    reset_quiet();
    fetch_after_store(12);
    load_over_fetch();
    serial_store();
    timer_halves();
    error_load();
    repeat (2) @(negedge clk);

    $display("checks done: %0d mismatches, %0d other errors", mismatch_cnt, fail_cnt);
    if ((mismatch_cnt == 0) && (fail_cnt == 0))
      $display("sim passed");
    else
      $display("sim failed");
    $finish;
  end

endmodule

`default_nettype wire

/* files.f */
design/bus_map_pkg.sv
design/axi_pkg.sv
design/dev_if.sv
design/clint_timer.sv
design/uart_sink.sv
design/axi_master_bridge.sv
design/bus_arbiter.sv
design/bus_top.sv
verif/bus_tb.sv

/* run.sh */
#!/bin/sh
# build and run the bus testbench with Verilator
cd "$(dirname "$0")" || exit 1
verilator --binary --timing --top-module bus_tb -f files.f -o bus_sim || exit 1
out="$(./obj_dir/bus_sim)"
echo "$out"
echo "$out" | grep -qx "sim passed" && exit 0 || exit 1
